// ==== Makefile ====
# Verilator flow for the console host services block

VERILATOR ?= verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_gb_host
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
verilog/gb_host_pkg.sv
verilog/download_decode.sv
verilog/cheat_loader.sv
verilog/backup_sequencer.sv
verilog/backup_data_router.sv
verilog/ffwd_latch.sv
verilog/gb_host_top.sv
tb/tb_gb_host.sv

// ==== tb/tb_gb_host.sv ====
//////////////////////////////
// Host services testbench
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_gb_host
	import gb_host_pkg::*;
();
	localparam int NCASES  = 16;
	localparam int K_CLASS = 0;
	localparam int K_CHEAT = 1;
	localparam int K_LOAD  = 2;
	localparam int K_SAVE  = 3;
	localparam int K_AUTO  = 4;
	localparam int K_FF    = 5;

	// Kind, index or ram_mask or hold cycles, rtc_inuse, then two expected values
	int kind_tbl [NCASES] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 2, 2, 3, 4, 5, 5};
	int p0_tbl   [NCASES] = '{'h01, 'h41, 'h80, 'h04, 'h05, 'h06, 'hFF, 'h02,
		0, 0, 2, 1, 1, 0, 60, 10};
	int p1_tbl   [NCASES] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0};
	// Class cases expect core_reset and gg_reset and the others a count or a level
	int e0_tbl   [NCASES] = '{1, 1, 1, 1, 1, 1, 0, 0, 1, 1, 3, 3, 3, 1, 0, 1};
	int e1_tbl   [NCASES] = '{1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     ioctl_download;
	logic [FILETYPE_W-1:0]    ioctl_index;
	logic [IOCTL_ADDR_W-1:0]  ioctl_addr;
	logic [IOCTL_DATA_W-1:0]  ioctl_dout;
	logic                     ioctl_wr;
	logic                     img_mounted;
	logic                     img_readonly;
	logic [IMG_SIZE_W-1:0]    img_size;
	logic                     cart_has_save;
	logic                     cram_wr;
	logic                     osd_status;
	logic                     autosave_en;
	logic                     load_req;
	logic                     save_req;
	logic                     rtc_inuse;
	logic [BLK_IDX_W-1:0]     ram_mask;
	logic                     sd_ack = 1'b0;
	logic [SD_BUF_ADDR_W-1:0] sd_buff_addr = '0;
	logic                     sd_buff_wr = 1'b0;
	logic [IOCTL_DATA_W-1:0]  sd_buff_dout = '0;
	logic [15:0]              bk_q;
	logic [RTC_STAMP_W-1:0]   rtc_timestamp;
	logic [RTC_SAVED_W-1:0]   rtc_savedtime;
	logic                     ff_button;
	logic                     core_reset;
	logic [CHEAT_W-1:0]       gg_code;
	logic                     gg_reset;
	logic [SD_LBA_W-1:0]      sd_lba;
	logic                     sd_rd;
	logic                     sd_wr;
	logic [15:0]              sd_buff_din;
	logic                     bk_busy;
	logic                     bk_loading;
	logic                     sav_pending;
	logic [BK_ADDR_W-1:0]     bk_addr;
	logic                     bk_wr;
	logic                     bk_rtc_wr;
	logic [15:0]              bk_data;
	logic                     fast_forward;
	logic                     led_user;

	// SD host model state
	logic [1:0]  h_state = 2'd0;
	logic        h_save = 1'b0;
	int          h_cnt = 0;
	int          h_blk = 0;
	int          blk_next = 0;
	int          rd_reqs = 0;
	int          wr_reqs = 0;
	int          rtc_save_wr = 0;
	logic [15:0] last_din [0:7];

	integer seed = 33;
	int     errors = 0;
	int     checks = 0;
	int     cases_run = 0;
	logic   timed_out = 1'b0;

	gb_host_top #(
		.FF_HOLD_CYCLES(40)
	) dut_i (.*);

	always #5 clk_sys = ~clk_sys;

	//////////////////////////////
	// SD host model
	//////////////////////////////
	// Ack 3 cycles after a request, then 256 buffer words, then ack drops
	always @(posedge clk_sys) begin
		if (reset) begin
			h_state    <= 2'd0;
			sd_ack     <= 1'b0;
			sd_buff_wr <= 1'b0;
		end else begin
			// Block numbers restart with each transfer
			if (!bk_busy)
				blk_next <= 0;
			case (h_state)
				2'd0: begin
					if (sd_rd || sd_wr) begin
						h_save   <= sd_wr;
						h_blk    <= blk_next;
						blk_next <= blk_next + 1;
						rd_reqs  <= rd_reqs + (sd_rd ? 1 : 0);
						wr_reqs  <= wr_reqs + (sd_wr ? 1 : 0);
						h_cnt    <= 0;
						h_state  <= 2'd1;
					end
				end
				2'd1: begin
					if (h_cnt == 2) begin
						sd_ack       <= 1'b1;
						sd_buff_addr <= '0;
						sd_buff_wr   <= ~h_save;
						sd_buff_dout <= 16'($random(seed));
						h_cnt        <= 0;
						h_state      <= 2'd2;
					end else
						h_cnt <= h_cnt + 1;
				end
				default: begin
					if (h_cnt == 255) begin
						sd_ack     <= 1'b0;
						sd_buff_wr <= 1'b0;
						h_state    <= 2'd0;
					end else begin
						h_cnt        <= h_cnt + 1;
						sd_buff_addr <= sd_buff_addr + 8'd1;
						sd_buff_dout <= 16'($random(seed));
					end
				end
			endcase
		end
	end

	always @(negedge clk_sys) begin
		// Router outputs against the block being transferred
		if (h_state == 2'd2) begin
			check_eq("sd_lba", 128'(sd_lba), 128'(h_blk));
			check_eq("bk_addr", 128'(bk_addr), 128'(h_blk * 256 + sd_buff_addr));
			if (!h_save) begin
				check_eq("bk_wr", 128'(bk_wr), 128'(h_blk <= ram_mask));
				check_eq("bk_rtc_wr", 128'(bk_rtc_wr), 128'(h_blk > ram_mask));
				check_eq("bk_data", 128'(bk_data), 128'(sd_buff_dout));
			end else if (h_blk <= ram_mask)
				check_eq("sd_buff_din", 128'(sd_buff_din), 128'(bk_q));
		end
		// Keeps the first read-back words of the latest save block
		if (h_state == 2'd2 && h_save) begin
			if (bk_rtc_wr)
				rtc_save_wr <= rtc_save_wr + 1;
			if (sd_buff_addr < 8'd6)
				last_din[sd_buff_addr[2:0]] <= sd_buff_din;
		end
	end

	//////////////////////////////
	// Checks and waits
	//////////////////////////////
	task automatic check_eq(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Core must stay in reset for the whole load when watch_reset is set
	task automatic wait_busy(input logic level, input int limit, input logic watch_reset);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (bk_busy !== level && n < limit) begin
			if (watch_reset)
				check_eq("core_reset", 128'(core_reset), 128'(1));
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: bk_busy did not go to %0b within %0d cycles", level, limit);
		end
	endtask

	function automatic string kind_name(input int kind);
		case (kind)
			K_CLASS: return "download class";
			K_CHEAT: return "cheat assembly";
			K_LOAD:  return "backup load";
			K_SAVE:  return "save read-back";
			K_AUTO:  return "autosave";
			default: return "fast-forward";
		endcase
	endfunction

	//////////////////////////////
	// Case runners
	//////////////////////////////
	task automatic run_class(input logic [7:0] index, input int exp_core, input int exp_gg);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		@(negedge clk_sys);
		check_eq("core_reset", 128'(core_reset), 128'(exp_core));
		check_eq("gg_reset", 128'(gg_reset), 128'(exp_gg));
		// Download lasts past the cart load start strobe
		repeat (2) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("core_reset", 128'(core_reset), 128'(0));
	endtask

	task automatic run_cheat();
		logic [15:0] words [0:7];
		int          pulses;
		pulses = 0;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= 8'hFF;
		for (int w = 0; w < 8; w++) begin
			words[w] = 16'($random(seed));
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= 25'(2 * w);
			ioctl_dout <= words[w];
			@(negedge clk_sys);
			if (w == 0)
				check_eq("gg_reset", 128'(gg_reset), 128'(1));
			pulses += gg_code[128] ? 1 : 0;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			@(negedge clk_sys);
			pulses += gg_code[128] ? 1 : 0;
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(negedge clk_sys);
		pulses += gg_code[128] ? 1 : 0;
		check_eq("gg_code clock pulses", 128'(pulses), 128'(1));
		// Flags then address, compare and replace with each low word first
		check_eq("gg_code", 128'(gg_code[127:0]), {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]});
	endtask

	task automatic run_backup(input logic is_load, input int mask, input int rtc,
			input int exp_reqs);
		int rd0;
		int wr0;
		@(posedge clk_sys);
		ram_mask  <= 8'(mask);
		rtc_inuse <= (rtc != 0);
		rd0 = rd_reqs;
		wr0 = wr_reqs;
		@(posedge clk_sys);
		load_req <= is_load;
		save_req <= ~is_load;
		@(posedge clk_sys);
		load_req <= 1'b0;
		save_req <= 1'b0;
		wait_busy(1'b1, 20, 1'b0);
		if (!timed_out) begin
			check_eq("bk_loading", 128'(bk_loading), 128'(is_load));
			wait_busy(1'b0, 5000, is_load);
		end
		if (is_load)
			check_eq("sd_rd requests", 128'(rd_reqs - rd0), 128'(exp_reqs));
		else
			check_eq("sd_wr requests", 128'(wr_reqs - wr0), 128'(exp_reqs));
	endtask

	task automatic run_save(input int mask, input int rtc, input int exp_reqs);
		int wr0;
		wr0 = rtc_save_wr;
		@(posedge clk_sys);
		rtc_timestamp <= 32'($random(seed));
		rtc_savedtime <= {16'($random(seed)), 32'($random(seed))};
		run_backup(1'b0, mask, rtc, exp_reqs);
		check_eq("sd_buff_din[0]", 128'(last_din[0]), 128'(rtc_timestamp[15:0]));
		check_eq("sd_buff_din[1]", 128'(last_din[1]), 128'(rtc_timestamp[31:16]));
		check_eq("sd_buff_din[2]", 128'(last_din[2]), 128'(rtc_savedtime[15:0]));
		check_eq("sd_buff_din[3]", 128'(last_din[3]), 128'(rtc_savedtime[31:16]));
		check_eq("sd_buff_din[4]", 128'(last_din[4]), 128'(rtc_savedtime[47:32]));
		check_eq("sd_buff_din[5]", 128'(last_din[5]), 128'(16'hFFFF));
		check_eq("bk_rtc_wr during save", 128'(rtc_save_wr - wr0), 128'(0));
	endtask

	task automatic run_autosave(input int mask, input int rtc, input int exp_reqs);
		int wr0;
		@(posedge clk_sys);
		ram_mask  <= 8'(mask);
		rtc_inuse <= (rtc != 0);
		cram_wr   <= 1'b1;
		wr0 = wr_reqs;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		check_eq("led_user", 128'(led_user), 128'(1));
		// Opening the menu with autosave on starts the save
		@(posedge clk_sys);
		osd_status  <= 1'b1;
		autosave_en <= 1'b1;
		wait_busy(1'b1, 20, 1'b0);
		if (!timed_out)
			wait_busy(1'b0, 5000, 1'b0);
		check_eq("sav_pending", 128'(sav_pending), 128'(0));
		check_eq("led_user", 128'(led_user), 128'(0));
		check_eq("sd_wr requests", 128'(wr_reqs - wr0), 128'(exp_reqs));
		@(posedge clk_sys);
		osd_status  <= 1'b0;
		autosave_en <= 1'b0;
	endtask

	task automatic run_ffwd(input int hold, input int exp_ff);
		@(posedge clk_sys);
		ff_button <= 1'b1;
		repeat (hold) @(posedge clk_sys);
		ff_button <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("fast_forward", 128'(fast_forward), 128'(exp_ff));
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int i;
		int err0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		img_mounted    = 1'b1;
		img_readonly   = 1'b0;
		img_size       = '0;
		cart_has_save  = 1'b1;
		cram_wr        = 1'b0;
		osd_status     = 1'b0;
		autosave_en    = 1'b0;
		load_req       = 1'b0;
		save_req       = 1'b0;
		rtc_inuse      = 1'b0;
		ram_mask       = '0;
		bk_q           = 16'($random(seed));
		rtc_timestamp  = '0;
		rtc_savedtime  = '0;
		ff_button      = 1'b0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		for (i = 0; i < NCASES && !timed_out; i++) begin
			err0 = errors;
			case (kind_tbl[i])
				K_CLASS: run_class(8'(p0_tbl[i]), e0_tbl[i], e1_tbl[i]);
				K_CHEAT: run_cheat();
				K_LOAD:  run_backup(1'b1, p0_tbl[i], p1_tbl[i], e0_tbl[i]);
				K_SAVE:  run_save(p0_tbl[i], p1_tbl[i], e0_tbl[i]);
				K_AUTO:  run_autosave(p0_tbl[i], p1_tbl[i], e0_tbl[i]);
				default: run_ffwd(p0_tbl[i], e0_tbl[i]);
			endcase
			cases_run++;
			$display("case %0d %s: %s", i, kind_name(kind_tbl[i]),
				(errors == err0) ? "ok" : "FAILED");
		end
		$display("%0d cases run, %0d checks, %0d errors", cases_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/backup_data_router.sv ====
//////////////////////////////
// Backup data routing
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backup_data_router
	import gb_host_pkg::*;
(
	input  logic [SD_LBA_W-1:0]      sd_lba,
	input  logic [SD_BUF_ADDR_W-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	input  logic                     sd_ack,
	input  logic                     in_rtc_block,
	input  logic [IOCTL_DATA_W-1:0]  sd_buff_dout,
	input  logic [15:0]              bk_q,
	input  logic [RTC_STAMP_W-1:0]   rtc_timestamp,
	input  logic [RTC_SAVED_W-1:0]   rtc_savedtime,
	output logic [BK_ADDR_W-1:0]     bk_addr,
	output logic                     bk_wr,
	output logic                     bk_rtc_wr,
	output logic [15:0]              bk_data,
	output logic [15:0]              sd_buff_din
);
	logic [15:0] rtc_word;

	// Block number selects the 256-word page of backup RAM
	assign bk_addr = {sd_lba[BK_ADDR_W-SD_BUF_ADDR_W-1:0], sd_buff_addr};
	assign bk_data = sd_buff_dout;

	assign bk_wr     = sd_buff_wr & sd_ack & ~in_rtc_block;
	assign bk_rtc_wr = sd_buff_wr & sd_ack & in_rtc_block;

	// Clock block holds timestamp then saved time, rest padded
	always_comb begin
		case (sd_buff_addr)
			SD_BUF_ADDR_W'(0): rtc_word = rtc_timestamp[15:0];
			SD_BUF_ADDR_W'(1): rtc_word = rtc_timestamp[31:16];
			SD_BUF_ADDR_W'(2): rtc_word = rtc_savedtime[15:0];
			SD_BUF_ADDR_W'(3): rtc_word = rtc_savedtime[31:16];
			SD_BUF_ADDR_W'(4): rtc_word = rtc_savedtime[47:32];
			default:           rtc_word = 16'hFFFF;
		endcase
	end

	assign sd_buff_din = in_rtc_block ? rtc_word : bk_q;

endmodule

`default_nettype wire

// ==== verilog/backup_sequencer.sv ====
//////////////////////////////
// Backup RAM load/save
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer
	import gb_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  logic                  cart_load_start,
	input  logic                  cart_load_done,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [IMG_SIZE_W-1:0] img_size,
	input  logic                  cart_has_save,
	input  logic                  cram_wr,
	input  logic                  osd_status,
	input  logic                  autosave_en,
	input  logic                  load_req,
	input  logic                  save_req,
	input  logic                  rtc_inuse,
	input  logic [BLK_IDX_W-1:0]  ram_mask,
	input  logic                  sd_ack,
	output logic [SD_LBA_W-1:0]   sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  in_rtc_block,
	output logic                  sav_pending
);
	bk_state_e            state;
	logic                 bk_ena;
	logic                 sav_supported;
	logic                 auto_save;
	logic                 load_q;
	logic                 save_q;
	logic                 auto_q;
	logic                 ack_q;
	logic                 start_load;
	logic                 start_save;
	logic [BLK_IDX_W-1:0] blk_idx;
	logic                 last_blk;

	assign sav_supported = cart_has_save & bk_ena;
	assign auto_save     = sav_pending & osd_status & autosave_en;
	assign start_load    = (load_req & ~load_q) | (cart_load_done & |img_size);
	assign start_save    = (save_req & ~save_q) | (auto_save & ~auto_q);

	// Clock data rides in the block after the last RAM block
	assign blk_idx      = sd_lba[BLK_IDX_W-1:0];
	assign in_rtc_block = blk_idx > ram_mask;
	assign last_blk     = rtc_inuse ? in_rtc_block : (blk_idx >= ram_mask);
	assign bk_busy      = (state != BK_IDLE);

	//////////////////////////////
	// Save enable, pending flag
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (cart_load_start)
				bk_ena <= 1'b0;
			// The save image gets mounted before the ROM download ends
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
			auto_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_req;
			auto_q <= auto_save;
			ack_q  <= sd_ack;
		end
	end

	//////////////////////////////
	// Block FSM
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				BK_IDLE: begin
					// Load wins if both arrive together
					if (bk_ena && (start_load || start_save)) begin
						state      <= BK_REQ;
						sd_lba     <= '0;
						bk_loading <= start_load;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				BK_REQ: begin
					if (sd_ack && !ack_q) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_WAIT_END;
					end
				end
				BK_WAIT_END: begin
					// Host drops ack once the 256 buffer words are done
					if (!sd_ack && ack_q) begin
						if (last_blk) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= BK_REQ;
							sd_lba <= sd_lba + SD_LBA_W'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cheat_loader.sv ====
//////////////////////////////
// Cheat code assembly
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cheat_loader
	import gb_host_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0] ioctl_dout,
	input  dl_kind_e                dl_kind,
	output logic [CHEAT_W-1:0]      gg_code,
	output logic                    gg_reset
);
	logic               cheat_wr;
	logic               code_clk;
	logic [CHEAT_W-2:0] code_fields;

	assign cheat_wr = ioctl_wr && (dl_kind == DL_CHEAT);

	// First word of a new cheat list wipes the old codes, as does a new cart
	assign gg_reset = (dl_kind == DL_CART) || (cheat_wr && ioctl_addr == '0);

	assign gg_code = {code_clk, code_fields};

	// Last word of a record clocks it into the core
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_clk <= 1'b0;
		else
			code_clk <= cheat_wr && (ioctl_addr[3:0] == 4'd14);
	end

	// Words arrive bottom half first, fields are big endian as stored
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code_fields[111:96]  <= ioctl_dout;
				4'd2:  code_fields[127:112] <= ioctl_dout;
				4'd4:  code_fields[79:64]   <= ioctl_dout;
				4'd6:  code_fields[95:80]   <= ioctl_dout;
				4'd8:  code_fields[47:32]   <= ioctl_dout;
				4'd10: code_fields[63:48]   <= ioctl_dout;
				4'd12: code_fields[15:0]    <= ioctl_dout;
				4'd14: code_fields[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/download_decode.sv ====
//////////////////////////////
// Download class decode
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module download_decode
	import gb_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  logic [FILETYPE_W-1:0] ioctl_index,
	input  logic                  bk_loading,
	output dl_kind_e              dl_kind,
	output logic                  cart_download,
	output logic                  cart_load_start,
	output logic                  cart_load_done,
	output logic                  core_reset
);
	logic cart_dl_q;
	logic boot_download;

	always_comb begin
		if (!ioctl_download)
			dl_kind = DL_NONE;
		else if (ioctl_index[5:0] == FT_CART[5:0] || ioctl_index == FT_CART_ALT)
			dl_kind = DL_CART;
		else if (ioctl_index == FT_BOOT_CGB || ioctl_index == FT_BOOT_DMG ||
				ioctl_index == FT_BOOT_SGB)
			dl_kind = DL_BOOT;
		else if (ioctl_index == FT_CHEAT)
			dl_kind = DL_CHEAT;
		else
			dl_kind = DL_OTHER;
	end

	assign cart_download = (dl_kind == DL_CART);
	assign boot_download = (dl_kind == DL_BOOT);

	// Core held in reset while ROM or boot image is loaded, and during backup restore
	assign core_reset = reset | cart_download | boot_download | bk_loading;

	// Edge strobes, one cycle late
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q       <= 1'b0;
			cart_load_start <= 1'b0;
			cart_load_done  <= 1'b0;
		end else begin
			cart_dl_q       <= cart_download;
			cart_load_start <= cart_download & ~cart_dl_q;
			cart_load_done  <= cart_dl_q & ~cart_download;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ffwd_latch.sv ====
//////////////////////////////
// Fast-forward latch
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ffwd_latch #(
	parameter int FF_HOLD_CYCLES = 3200000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ff_button,
	input  logic ioctl_download,
	input  logic osd_status,
	output logic fast_forward
);
	localparam int CNT_W = $clog2(FF_HOLD_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(FF_HOLD_CYCLES);

	logic             ff_active;
	logic             ff_last;
	logic             ff_latch;
	logic             ff_was_held;
	logic [CNT_W-1:0] ff_count;

	// Button ignored while loading or with the menu up
	assign ff_active = ff_button & ~ioctl_download & ~osd_status;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ff_last      <= 1'b0;
			ff_latch     <= 1'b0;
			ff_was_held  <= 1'b0;
			ff_count     <= '0;
			fast_forward <= 1'b0;
		end else begin
			ff_last <= ff_active;
			// Saturates so a long hold never looks like a tap
			if (ff_active && ff_count != CNT_MAX)
				ff_count <= ff_count + 1'b1;
			if (ff_active && !ff_last) begin
				ff_latch <= 1'b0;
				ff_count <= '0;
			end
			// Short tap toggles, the tap after a latch only releases it
			if (!ff_active && ff_last) begin
				ff_was_held <= 1'b0;
				if (ff_count < CNT_MAX && !ff_was_held) begin
					ff_was_held <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end
			fast_forward <= ff_active | ff_latch;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/gb_host_pkg.sv ====
//////////////////////////////
// Host service definitions
//////////////////////////////
`default_nettype none

package gb_host_pkg;

	// Download stream
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int FILETYPE_W   = 8;

	// Download index codes, cart is matched on its low six bits
	localparam logic [FILETYPE_W-1:0] FT_CART     = 8'h01;
	localparam logic [FILETYPE_W-1:0] FT_CART_ALT = 8'h80;
	localparam logic [FILETYPE_W-1:0] FT_BOOT_CGB = 8'h04;
	localparam logic [FILETYPE_W-1:0] FT_BOOT_DMG = 8'h05;
	localparam logic [FILETYPE_W-1:0] FT_BOOT_SGB = 8'h06;
	localparam logic [FILETYPE_W-1:0] FT_CHEAT    = 8'hFF;

	typedef enum logic [2:0] {
		DL_NONE,
		DL_CART,
		DL_BOOT,
		DL_CHEAT,
		DL_OTHER
	} dl_kind_e;

	// Clock bit, flags, address, compare, replace
	localparam int CHEAT_W = 129;

	// Backup RAM and SD side
	localparam int SD_LBA_W      = 32;
	localparam int BLK_IDX_W     = 8;
	localparam int SD_BUF_ADDR_W = 8;
	localparam int BK_ADDR_W     = 17;
	localparam int IMG_SIZE_W    = 64;
	localparam int RTC_STAMP_W   = 32;
	localparam int RTC_SAVED_W   = 48;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_WAIT_END
	} bk_state_e;

endpackage

`default_nettype wire

// ==== verilog/gb_host_top.sv ====
//////////////////////////////
// Console host services
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gb_host_top
	import gb_host_pkg::*;
#(
	parameter int FF_HOLD_CYCLES = 3200000
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	// Download stream
	input  logic                     ioctl_download,
	input  logic [FILETYPE_W-1:0]    ioctl_index,
	input  logic [IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0]  ioctl_dout,
	input  logic                     ioctl_wr,
	// Save image and cart state
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [IMG_SIZE_W-1:0]    img_size,
	input  logic                     cart_has_save,
	input  logic                     cram_wr,
	input  logic                     osd_status,
	input  logic                     autosave_en,
	input  logic                     load_req,
	input  logic                     save_req,
	input  logic                     rtc_inuse,
	input  logic [BLK_IDX_W-1:0]     ram_mask,
	// SD host side
	input  logic                     sd_ack,
	input  logic [SD_BUF_ADDR_W-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	input  logic [IOCTL_DATA_W-1:0]  sd_buff_dout,
	input  logic [15:0]              bk_q,
	input  logic [RTC_STAMP_W-1:0]   rtc_timestamp,
	input  logic [RTC_SAVED_W-1:0]   rtc_savedtime,
	input  logic                     ff_button,
	output logic                     core_reset,
	output logic [CHEAT_W-1:0]       gg_code,
	output logic                     gg_reset,
	output logic [SD_LBA_W-1:0]      sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [15:0]              sd_buff_din,
	output logic                     bk_busy,
	output logic                     bk_loading,
	output logic                     sav_pending,
	output logic [BK_ADDR_W-1:0]     bk_addr,
	output logic                     bk_wr,
	output logic                     bk_rtc_wr,
	output logic [15:0]              bk_data,
	output logic                     fast_forward,
	output logic                     led_user
);
	dl_kind_e dl_kind;
	logic     cart_download;
	logic     cart_load_start;
	logic     cart_load_done;
	logic     in_rtc_block;

	download_decode download_decode_i (.*);

	cheat_loader cheat_loader_i (.*);

	backup_sequencer backup_sequencer_i (.*);

	backup_data_router backup_data_router_i (.*);

	ffwd_latch #(
		.FF_HOLD_CYCLES(FF_HOLD_CYCLES)
	) ffwd_latch_i (.*);

	// Lit while a ROM streams in or unsaved RAM changes exist
	assign led_user = cart_download | sav_pending;

endmodule

`default_nettype wire
